/* common/periph_mem_config.svh */
/*
 * Build-time constants for the peripheral memory subsystem.
 * Include this header wherever a width, base address, line timing value
 * or the flash credit count is needed.
 */
`ifndef PERIPH_MEM_CONFIG_SVH
`define PERIPH_MEM_CONFIG_SVH

`define PM_ADDR_W        14       // 16K words.
`define PM_DATA_W        16
`define PM_FETCH_LEN     8        // Words per fetch burst.
`define PM_LINE_PERIOD   64       // Cycles per display line.
`define PM_LINES         4        // Lines per frame.
`define PM_LINE_W        2        // Width of the line index.
`define PM_SPRITE_BASE   14'h3f00 // Sprite attribute table.
`define PM_BG_BASE       14'h3e00 // Tile map, one run per line.
`define PM_FLASH_CREDITS 4        // Flash FIFO depth and initial credits.

`endif

/* common/periph_mem_pkg.sv */
/*
 * Types shared by the peripheral memory RTL and its testbench:
 * grant codes, RAM request records and the fetched payload records.
 * Import with a wildcard in the module header.
 */
`default_nettype none

`include "periph_mem_config.svh"

package periph_mem_pkg;

	// Encoding is the arbiter state encoding.
	typedef enum logic [1:0] {
		GNT_CPU    = 2'd0,
		GNT_FLASH  = 2'd1,
		GNT_BG0    = 2'd2,
		GNT_SPRITE = 2'd3
	} grant_t;

	// ########################################
	// Requests.
	typedef struct packed {
		logic                  valid;
		logic [`PM_ADDR_W-1:0] addr;
		logic [`PM_DATA_W-1:0] wdata;
		logic                  wr;
		logic [1:0]            wr_mask; // One bit per byte.
	} mem_req_t;

	typedef struct packed {
		logic                  valid;
		logic [`PM_ADDR_W-1:0] addr;
	} rd_req_t;

	typedef struct packed {
		logic                  valid;
		logic [`PM_ADDR_W-1:0] addr;
		logic [`PM_DATA_W-1:0] data;
	} flash_word_t;

	// ########################################
	// Payloads.
	typedef struct packed {
		logic [7:0] y_off;
		logic [6:0] tile;
		logic       flip;
	} sprite_attr_t;

	typedef struct packed {
		logic [3:0]  palette;
		logic [11:0] tile;
	} tile_word_t;

	typedef struct packed {
		logic         valid;
		sprite_attr_t attr;
	} sprite_out_t;

	typedef struct packed {
		logic       valid;
		tile_word_t word;
	} tile_out_t;

endpackage

`default_nettype wire

/* rtl/periph_mem_arbiter.sv */
/*
 * Arbiter for the single RAM port.
 * Priority is sprite, background, flash, then CPU. A grant is held while
 * its requester keeps valid high and falls back to CPU one cycle after it
 * drops. The granted request is steered onto ram_req.
 */
`default_nettype none

module periph_mem_arbiter
	import periph_mem_pkg::*;
(
	input  wire logic     CLK,
	input  wire logic     RSTb,
	input  wire mem_req_t cpu_req,
	input  wire mem_req_t fl_req,
	input  wire rd_req_t  bg_req,
	input  wire rd_req_t  spr_req,
	output grant_t        grant,
	output logic          cpu_ready,
	output mem_req_t      ram_req
);

	grant_t state_r;

	assign grant     = state_r;
	assign cpu_ready = (state_r == GNT_CPU); // CPU only owns the port when idle.

	// ########################################
	// Request steering.
	always_comb begin
		ram_req = '0;
		case (state_r)
			GNT_CPU: begin
				ram_req = cpu_req;
			end
			GNT_FLASH: begin
				ram_req = fl_req; // Loader issues whole-word writes.
			end
			GNT_BG0: begin
				ram_req.valid = bg_req.valid;
				ram_req.addr  = bg_req.addr;
			end
			GNT_SPRITE: begin
				ram_req.valid = spr_req.valid;
				ram_req.addr  = spr_req.addr;
			end
			default: ram_req = '0;
		endcase
	end

	// ########################################
	// Grant state.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_r <= GNT_CPU;
		end else begin
			case (state_r)
				GNT_CPU: begin
					if (spr_req.valid)
						state_r <= GNT_SPRITE;
					else if (bg_req.valid)
						state_r <= GNT_BG0;
					else if (fl_req.valid)
						state_r <= GNT_FLASH;
				end
				GNT_SPRITE: if (!spr_req.valid) state_r <= GNT_CPU;
				GNT_BG0:    if (!bg_req.valid) state_r <= GNT_CPU;
				GNT_FLASH:  if (!fl_req.valid) state_r <= GNT_CPU;
				default:    state_r <= GNT_CPU;
			endcase
		end
	end

	// A fetcher only holds the port if it was requesting the cycle before.
	a_spr_hold: assert property (@(posedge CLK) disable iff (!RSTb)
		(state_r == GNT_SPRITE) |-> $past(spr_req.valid));

	a_bg_hold: assert property (@(posedge CLK) disable iff (!RSTb)
		(state_r == GNT_BG0) |-> $past(bg_req.valid));

	// Flash writes must cover both bytes.
	a_flash_mask: assert property (@(posedge CLK) disable iff (!RSTb)
		(state_r == GNT_FLASH && ram_req.valid) |-> (ram_req.wr && ram_req.wr_mask == 2'b11));

endmodule

`default_nettype wire

/* rtl/fetch/fetch_timer.sv */
/*
 * Display line timer.
 * Counts columns up to the line period, pulses line_start at the wrap
 * and keeps the index of the line the fetchers should read for.
 */
`default_nettype none

`include "periph_mem_config.svh"

module fetch_timer (
	input  wire logic                   CLK,
	input  wire logic                   RSTb,
	output logic                        line_start,
	output logic [`PM_LINE_W-1:0]       line_idx
);

	localparam int COL_W = $clog2(`PM_LINE_PERIOD);

	logic [COL_W-1:0]      col_r;
	logic [`PM_LINE_W-1:0] line_r;

	assign line_start = (col_r == COL_W'(`PM_LINE_PERIOD - 1)); // Last column of the line.
	assign line_idx   = line_r;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			col_r  <= '0;
			line_r <= '0;
		end else begin
			if (line_start) begin
				col_r <= '0;
				if (line_r == `PM_LINE_W'(`PM_LINES - 1))
					line_r <= '0; // Wrap at end of frame.
				else
					line_r <= line_r + 1'b1;
			end else begin
				col_r <= col_r + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/fetch/fetch_engine.sv */
/*
 * Burst reader for one display fetcher.
 * On start it reads PM_FETCH_LEN consecutive words from base, one per
 * granted cycle, and presents each word one cycle after its read as
 * payload_t. The output cannot be stalled.
 */
`default_nettype none

`include "periph_mem_config.svh"

module fetch_engine
	import periph_mem_pkg::*;
#(
	parameter type    payload_t = logic [`PM_DATA_W-1:0],
	parameter grant_t GRANT_ID  = GNT_SPRITE
) (
	input  wire logic                  CLK,
	input  wire logic                  RSTb,
	input  wire logic                  start,
	input  wire logic [`PM_ADDR_W-1:0] base,
	input  wire grant_t                grant,
	input  wire logic [`PM_DATA_W-1:0] rdata,
	output rd_req_t                    req,
	output logic                       out_valid,
	output payload_t                   out_data
);

	localparam int CNT_W = $clog2(`PM_FETCH_LEN + 1);

	logic [`PM_ADDR_W-1:0] addr_r;
	logic [CNT_W-1:0]      cnt_r;   // Words still to request.
	logic                  pend_r;  // Read issued last cycle.
	logic                  take;

	assign req.valid = (cnt_r != '0);
	assign req.addr  = addr_r;

	// An address is consumed on every cycle we own the port.
	assign take = req.valid && (grant == GRANT_ID);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cnt_r  <= '0;
			pend_r <= 1'b0;
		end else begin
			pend_r <= take;
			if (start)
				cnt_r <= CNT_W'(`PM_FETCH_LEN);
			else if (take)
				cnt_r <= cnt_r - 1'b1;
		end
	end

	// Read address, reloaded from base at each start.
	always_ff @(posedge CLK) begin
		if (start)
			addr_r <= base;
		else if (take)
			addr_r <= addr_r + 1'b1;
	end

	// RAM read data is registered, so it lines up with the pending flag.
	assign out_valid = pend_r;
	assign out_data  = payload_t'(rdata);

endmodule

`default_nettype wire

/* rtl/flash_loader.sv */
/*
 * Flash write loader.
 * Buffers the incoming flash word stream in a small FIFO and presents the
 * head word as a full-word RAM write. Each word written returns one
 * credit to the sender, which starts with PM_FLASH_CREDITS.
 */
`default_nettype none

`include "periph_mem_config.svh"

module flash_loader
	import periph_mem_pkg::*;
(
	input  wire logic        CLK,
	input  wire logic        RSTb,
	input  wire flash_word_t flash_in,
	output mem_req_t         req,
	input  wire grant_t      grant,
	output logic             flash_credit
);

	localparam int DEPTH = `PM_FLASH_CREDITS;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [`PM_ADDR_W-1:0] addr_mem [DEPTH];
	logic [`PM_DATA_W-1:0] data_mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr_r;
	logic [PTR_W-1:0] rd_ptr_r;
	logic [CNT_W-1:0] count_r;
	logic             push;
	logic             pop;
	logic             full;

	assign push = flash_in.valid;
	assign full = (count_r == CNT_W'(DEPTH));
	assign pop  = req.valid && (grant == GNT_FLASH); // Word lands in RAM this cycle.

	assign flash_credit = pop;

	// ########################################
	// Head word as a write request.
	assign req.valid   = (count_r != '0);
	assign req.addr    = addr_mem[rd_ptr_r];
	assign req.wdata   = data_mem[rd_ptr_r];
	assign req.wr      = 1'b1;
	assign req.wr_mask = 2'b11;

	// ########################################
	// FIFO storage and pointers.
	always_ff @(posedge CLK) begin
		if (push) begin
			addr_mem[wr_ptr_r] <= flash_in.addr;
			data_mem[wr_ptr_r] <= flash_in.data;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
			count_r  <= '0;
		end else begin
			if (push)
				wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
			if (pop)
				rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
			case ({push, pop})
				2'b10:   count_r <= count_r + 1'b1;
				2'b01:   count_r <= count_r - 1'b1;
				default: count_r <= count_r;
			endcase
		end
	end

	// The sender's credits should never let it overrun the FIFO.
	a_no_overflow: assert property (@(posedge CLK) disable iff (!RSTb)
		push |-> !full);

endmodule

`default_nettype wire

/* rtl/periph_ram.sv */
/*
 * Single-port 16K x 16 peripheral RAM.
 * Writes are byte-masked by wr_mask; read data is registered and
 * appears one cycle after the address, holding the pre-write value.
 */
`default_nettype none

`include "periph_mem_config.svh"

module periph_ram
	import periph_mem_pkg::*;
(
	input  wire logic                  CLK,
	input  wire mem_req_t              req,
	output logic [`PM_DATA_W-1:0]      rdata
);

	localparam int WORDS = 1 << `PM_ADDR_W;

	logic [`PM_DATA_W-1:0] mem [WORDS];

	always_ff @(posedge CLK) begin
		if (req.valid && req.wr) begin
			if (req.wr_mask[0])
				mem[req.addr][7:0] <= req.wdata[7:0];  // Low byte.
			if (req.wr_mask[1])
				mem[req.addr][15:8] <= req.wdata[15:8]; // High byte.
		end
	end

	// Read every cycle. Old data on a same-address write.
	always_ff @(posedge CLK) begin
		rdata <= mem[req.addr];
	end

endmodule

`default_nettype wire

/* rtl/periph_mem_sys.sv */
/*
 * Peripheral memory subsystem top level.
 * Ties the line timer, the sprite and background fetchers, the flash
 * loader, the arbiter and the RAM together. The CPU gets a ready signal
 * and read data one cycle after an accepted read.
 */
`default_nettype none

`include "periph_mem_config.svh"

module periph_mem_sys
	import periph_mem_pkg::*;
(
	input  wire logic                  CLK,
	input  wire logic                  RSTb,
	input  wire mem_req_t              cpu_req,
	output logic                       cpu_ready,
	output logic                       cpu_rvalid,
	output logic [`PM_DATA_W-1:0]      cpu_rdata,
	input  wire flash_word_t           flash_in,
	output logic                       flash_credit,
	output sprite_out_t                sprite_out,
	output tile_out_t                  tile_out
);

	localparam logic [`PM_ADDR_W-1:0] SPR_BASE = `PM_SPRITE_BASE;
	localparam logic [`PM_ADDR_W-1:0] BG_BASE  = `PM_BG_BASE;
	localparam logic [`PM_ADDR_W-1:0] RUN_LEN  = `PM_FETCH_LEN;

	logic                  line_start;
	logic [`PM_LINE_W-1:0] line_idx;
	logic [`PM_ADDR_W-1:0] bg_base;
	logic [`PM_DATA_W-1:0] rdata;
	grant_t                grant;
	rd_req_t               spr_req;
	rd_req_t               bg_req;
	mem_req_t              fl_req;
	mem_req_t              ram_req;
	logic                  spr_valid;
	sprite_attr_t          spr_data;
	logic                  bg_valid;
	tile_word_t            bg_data;
	logic                  cpu_rd_r;

	// ########################################
	// Line timing and display fetchers.
	fetch_timer u_timer (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.line_start (line_start),
		.line_idx   (line_idx)
	);

	// Each line reads its own run of the tile map.
	assign bg_base = BG_BASE + `PM_ADDR_W'(line_idx) * RUN_LEN;

	fetch_engine #(.payload_t(sprite_attr_t), .GRANT_ID(GNT_SPRITE)) u_spr_fetch (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.start     (line_start),
		.base      (SPR_BASE),
		.grant     (grant),
		.rdata     (rdata),
		.req       (spr_req),
		.out_valid (spr_valid),
		.out_data  (spr_data)
	);

	fetch_engine #(.payload_t(tile_word_t), .GRANT_ID(GNT_BG0)) u_bg_fetch (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.start     (line_start),
		.base      (bg_base),
		.grant     (grant),
		.rdata     (rdata),
		.req       (bg_req),
		.out_valid (bg_valid),
		.out_data  (bg_data)
	);

	assign sprite_out = '{valid: spr_valid, attr: spr_data};
	assign tile_out   = '{valid: bg_valid, word: bg_data};

	// ########################################
	// Flash path, arbitration and RAM.
	flash_loader u_flash (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.flash_in     (flash_in),
		.req          (fl_req),
		.grant        (grant),
		.flash_credit (flash_credit)
	);

	periph_mem_arbiter u_arb (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.cpu_req   (cpu_req),
		.fl_req    (fl_req),
		.bg_req    (bg_req),
		.spr_req   (spr_req),
		.grant     (grant),
		.cpu_ready (cpu_ready),
		.ram_req   (ram_req)
	);

	periph_ram u_ram (
		.CLK   (CLK),
		.req   (ram_req),
		.rdata (rdata)
	);

	// CPU read returns on the next cycle.
	always_ff @(posedge CLK) begin
		if (!RSTb)
			cpu_rd_r <= 1'b0;
		else
			cpu_rd_r <= cpu_ready && cpu_req.valid && !cpu_req.wr;
	end

	assign cpu_rvalid = cpu_rd_r;
	assign cpu_rdata  = rdata;

endmodule

`default_nettype wire

/* dv/periph_mem_sys_tb.sv */
/*
 * Testbench for the peripheral memory subsystem.
 * Loads the RAM through the credit-limited flash stream, runs CPU traffic
 * alone and under contention, and checks every CPU read and every fetched
 * sprite and tile word against a reference memory model.
 */
`default_nettype none

`include "periph_mem_config.svh"

module periph_mem_sys_tb
	import periph_mem_pkg::*;
();

	localparam int LEN      = `PM_FETCH_LEN;
	localparam int PERIOD   = `PM_LINE_PERIOD;
	localparam int LINES    = `PM_LINES;
	localparam int CREDITS  = `PM_FLASH_CREDITS;
	localparam int POOL     = 64; // CPU test region, clear of the fetch tables.
	localparam int WATCHDOG = PERIOD * LINES * 6 + 2000;

	localparam logic [`PM_ADDR_W-1:0] SPR_BASE  = `PM_SPRITE_BASE;
	localparam logic [`PM_ADDR_W-1:0] BG_BASE   = `PM_BG_BASE;
	localparam logic [`PM_ADDR_W-1:0] POOL_BASE = 14'h0100;

	logic                  CLK = 1'b0;
	logic                  RSTb;
	mem_req_t              cpu_req;
	logic                  cpu_ready;
	logic                  cpu_rvalid;
	logic [`PM_DATA_W-1:0] cpu_rdata;
	flash_word_t           flash_in;
	logic                  flash_credit;
	sprite_out_t           sprite_out;
	tile_out_t             tile_out;

	logic [`PM_DATA_W-1:0] ref_mem [1 << `PM_ADDR_W];
	flash_word_t           fl_q[$];        // Words waiting to be sent.
	flash_word_t           fl_inflight[$]; // Sent, credit not yet back.
	integer                seed = 32'h286d_28ef;
	int                    fl_sent = 0;
	int                    fl_returned = 0;
	int                    cyc = -1;
	logic                  region_ready = 1'b0;
	logic                  rd_pend = 1'b0;
	logic [`PM_DATA_W-1:0] rd_exp;
	int                    spr_cnt = 0;
	int                    spr_burst = 0;
	int                    spr_checked = 0;
	logic                  spr_live = 1'b0;
	int                    tile_cnt = 0;
	int                    tile_burst = 0;
	int                    tile_checked = 0;
	logic                  tile_live = 1'b0;

	always #50 CLK = ~CLK;

	periph_mem_sys periph_mem_sys_i (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.cpu_req      (cpu_req),
		.cpu_ready    (cpu_ready),
		.cpu_rvalid   (cpu_rvalid),
		.cpu_rdata    (cpu_rdata),
		.flash_in     (flash_in),
		.flash_credit (flash_credit),
		.sprite_out   (sprite_out),
		.tile_out     (tile_out)
	);

	// ########################################
	// Reference model and checks.
	function automatic logic [`PM_DATA_W-1:0] ref_write(input logic [`PM_DATA_W-1:0] old,
			input logic [`PM_DATA_W-1:0] data, input logic [1:0] mask);
		logic [`PM_DATA_W-1:0] res;
		res = old;
		if (mask[0])
			res[7:0] = data[7:0];
		if (mask[1])
			res[15:8] = data[15:8];
		return res;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic compare_cpu(input string test, input logic [`PM_DATA_W-1:0] exp,
			input logic [`PM_DATA_W-1:0] act);
		if (act !== exp)
			stop_on_error($sformatf("ERR %s: expected %h, actual %h", test, exp, act));
	endtask

	task automatic compare_sprite(input string test, input sprite_attr_t exp,
			input sprite_attr_t act);
		if (act !== exp)
			stop_on_error($sformatf("ERR %s: expected %h, actual %h", test, exp, act));
	endtask

	task automatic compare_tile(input string test, input tile_word_t exp, input tile_word_t act);
		if (act !== exp)
			stop_on_error($sformatf("ERR %s: expected %h, actual %h", test, exp, act));
	endtask

	// Outputs are sampled mid-cycle, where they are settled.
	always @(negedge CLK) begin : monitor
		flash_word_t w;
		if (RSTb) begin
			cyc = cyc + 1;
			if (cpu_rvalid !== rd_pend)
				stop_on_error("cpu_rvalid did not follow an accepted read by one cycle.");
			if (rd_pend)
				compare_cpu("cpu_read", rd_exp, cpu_rdata);
			rd_pend = 1'b0;
			if (cpu_ready && cpu_req.valid) begin
				if (cpu_req.wr) begin
					ref_mem[cpu_req.addr] = ref_write(ref_mem[cpu_req.addr], cpu_req.wdata,
						cpu_req.wr_mask);
				end else begin
					rd_pend = 1'b1;
					rd_exp  = ref_mem[cpu_req.addr];
				end
			end
			if (flash_credit) begin
				if (fl_inflight.size() == 0)
					stop_on_error("Flash credit returned with no word in flight.");
				w = fl_inflight.pop_front();
				ref_mem[w.addr] = ref_write(ref_mem[w.addr], w.data, 2'b11); // Lands at this edge.
				fl_returned++;
			end
			if (sprite_out.valid) begin
				if (spr_cnt == 0)
					spr_live = region_ready;
				if (spr_live)
					compare_sprite($sformatf("sprite_fetch line %0d word %0d", spr_burst, spr_cnt),
						sprite_attr_t'(ref_mem[SPR_BASE + 14'(spr_cnt)]), sprite_out.attr);
				spr_cnt++;
				if (spr_cnt == LEN) begin
					spr_cnt = 0;
					spr_burst++;
					if (spr_live)
						spr_checked++;
				end
			end
			if (tile_out.valid) begin
				if (tile_cnt == 0)
					tile_live = region_ready;
				if (tile_live)
					compare_tile($sformatf("tile_fetch line %0d word %0d", tile_burst, tile_cnt),
						tile_word_t'(ref_mem[BG_BASE + 14'((tile_burst % LINES) * LEN + tile_cnt)]),
						tile_out.word);
				tile_cnt++;
				if (tile_cnt == LEN) begin
					tile_cnt = 0;
					tile_burst++;
					if (tile_live)
						tile_checked++;
				end
			end
		end
	end

	// ########################################
	// Stimulus.
	function automatic logic [`PM_ADDR_W-1:0] pool_addr();
		return POOL_BASE + 14'($random(seed) & (POOL - 1));
	endfunction

	task automatic queue_flash(input logic [`PM_ADDR_W-1:0] addr,
			input logic [`PM_DATA_W-1:0] data);
		fl_q.push_back('{valid: 1'b1, addr: addr, data: data});
	endtask

	task automatic wait_flash_drained();
		while (fl_q.size() != 0 || fl_returned != fl_sent)
			@(posedge CLK);
		repeat (2) @(posedge CLK);
		#10;
	endtask

	task automatic cpu_access(input logic wr, input logic [`PM_ADDR_W-1:0] addr,
			input logic [`PM_DATA_W-1:0] data, input logic [1:0] mask);
		cpu_req.valid   = 1'b1;
		cpu_req.addr    = addr;
		cpu_req.wdata   = data;
		cpu_req.wr      = wr;
		cpu_req.wr_mask = mask;
		@(negedge CLK);
		while (!cpu_ready)
			@(negedge CLK); // Held until accepted.
		@(posedge CLK);
		#10;
	endtask

	// Sends in groups of up to CREDITS words, then waits for all credits.
	initial begin : flash_sender
		int          group_left;
		flash_word_t w;
		flash_in   = '0;
		group_left = 0;
		forever begin
			@(posedge CLK);
			#10;
			flash_in = '0;
			if (group_left == 0 && fl_q.size() != 0 && fl_sent == fl_returned)
				group_left = CREDITS;
			if (group_left != 0 && fl_q.size() != 0 && fl_sent - fl_returned < CREDITS) begin
				w = fl_q.pop_front();
				flash_in = w;
				fl_inflight.push_back(w);
				fl_sent++;
				group_left--;
			end else begin
				group_left = 0;
			end
		end
	end

	initial begin : stimulus
		int i;
		cpu_req = '0;
		RSTb    = 1'b0;
		repeat (2) @(posedge CLK);
		#10;
		RSTb = 1'b1;
		@(negedge CLK);
		if (!cpu_ready || flash_credit || cpu_rvalid || sprite_out.valid || tile_out.valid)
			stop_on_error("Outputs are not in their reset state after reset.");

		// Flash load of both fetch tables and the CPU region.
		for (i = 0; i < LEN; i++)
			queue_flash(SPR_BASE + 14'(i), 16'($random(seed)));
		for (i = 0; i < LEN * LINES; i++)
			queue_flash(BG_BASE + 14'(i), 16'($random(seed)));
		for (i = 0; i < POOL; i++)
			queue_flash(POOL_BASE + 14'(i), 16'($random(seed)));
		for (i = 0; i < 16; i++)
			queue_flash(pool_addr(), 16'($random(seed)));
		wait_flash_drained();
		region_ready = 1'b1;

		// CPU writes with random masks, then reads.
		for (i = 0; i < 48; i++)
			cpu_access(1'b1, pool_addr(), 16'($random(seed)), 2'($random(seed)));
		for (i = 0; i < 48; i++)
			cpu_access(1'b0, pool_addr(), '0, 2'b00);
		cpu_req = '0;

		// Contention. Flash and CPU together across several lines.
		@(negedge CLK);
		for (i = 0; i < 60; i++)
			queue_flash(pool_addr(), 16'($random(seed)));
		@(posedge CLK);
		#10;
		for (i = 0; i < 160; i++)
			cpu_access(1'($random(seed)), pool_addr(), 16'($random(seed)), 2'($random(seed)));
		cpu_req = '0;
		wait_flash_drained();

		// Stop well after the last line start, once its bursts are done.
		while (cyc % PERIOD != 40) begin
			@(posedge CLK);
			#10;
		end
		if (spr_cnt != 0 || tile_cnt != 0) begin
			stop_on_error("A fetch burst ended short of its full length.");
		end else if (spr_burst != cyc / PERIOD || tile_burst != cyc / PERIOD) begin
			stop_on_error("The number of fetch bursts does not match the lines elapsed.");
		end else if (spr_checked < LINES || tile_checked < LINES) begin
			stop_on_error("Too few fetch bursts were compared.");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG) @(posedge CLK);
		stop_on_error("Timeout. The run did not finish in the expected number of cycles.");
	end

endmodule

`default_nettype wire

/* periph_mem_sys.f */
+incdir+common
common/periph_mem_pkg.sv
rtl/periph_mem_arbiter.sv
rtl/fetch/fetch_timer.sv
rtl/fetch/fetch_engine.sv
rtl/flash_loader.sv
rtl/periph_ram.sv
rtl/periph_mem_sys.sv
dv/periph_mem_sys_tb.sv

/* Makefile */
TOP := periph_mem_sys_tb

all: run

run:
	verilator --binary --timing --assert -f periph_mem_sys.f --top-module $(TOP) -o sim
	./obj_dir/sim | tee sim.log
	@grep -q "Result: PASSED" sim.log
	@! grep -q "Result: FAILED" sim.log

lint:
	verilator --lint-only --timing -f periph_mem_sys.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
